// File: src/spi_pkg.sv
`default_nettype none

package spi_pkg;

    // Frame length in bits
    localparam int DATA_W = 8;

    // Edges per frame plus one, so the final count fits
    localparam int EDGE_CNT_W = $clog2(2 * DATA_W + 1);

    // Half-period divider width
    localparam int CLK_DIV_W = 8;

    typedef logic [DATA_W-1:0]     spi_data_t;   // One transfer word
    typedef logic [CLK_DIV_W-1:0]  clk_div_t;    // Half-period reload value
    typedef logic [EDGE_CNT_W-1:0] edge_cnt_t;   // Edges seen in a frame

    // Transfer sequencing
    typedef enum logic [1:0] {
        IDLE,       // cs_n high, waiting for start
        LOAD,       // Copy tx word, optional priming shift
        TRANSFER,   // sclk running
        FINISH      // One cycle, done pulse
    } spi_state_t;

endpackage

`default_nettype wire

// File: src/apb_pkg.sv
`default_nettype none

package apb_pkg;

    typedef logic [3:0]  apb_addr_t;   // Byte offset within the block
    typedef logic [31:0] apb_data_t;   // Bus data

    localparam apb_addr_t REG_CTRL = 4'h0;   // Mode, start, status readback
    localparam apb_addr_t REG_DIV  = 4'h4;   // Half-period divider
    localparam apb_addr_t REG_TX   = 4'h8;   // Transmit word
    localparam apb_addr_t REG_RX   = 4'hC;   // Received word, read only

    // REG_CTRL bit positions
    localparam int CTRL_CPOL_BIT  = 0;
    localparam int CTRL_CPHA_BIT  = 1;
    localparam int CTRL_START_BIT = 2;   // Write one, reads back 0
    localparam int STAT_BUSY_BIT  = 8;
    localparam int STAT_DONE_BIT  = 9;   // Sticky until next start

endpackage

`default_nettype wire

// File: src/spi_ctrl_if.sv
`default_nettype none

interface spi_ctrl_if;

    logic run;              // Generator enable
    logic load_en;          // Copy tx word into shifter
    logic shift_en_rise;    // Shift allowed on sclk rise
    logic shift_en_fall;    // Shift allowed on sclk fall
    logic sample_en_rise;   // Sample allowed on sclk rise
    logic sample_en_fall;   // Sample allowed on sclk fall
    logic sclk_rise;        // One-cycle edge pulses
    logic sclk_fall;
    logic count_done;       // All edges of the frame produced

    modport fsm (output run, load_en, shift_en_rise, shift_en_fall,
                 output sample_en_rise, sample_en_fall, input count_done);
    modport gen (input run, output sclk_rise, sclk_fall, count_done);
    modport dp  (input load_en, shift_en_rise, shift_en_fall,
                 input sample_en_rise, sample_en_fall, sclk_rise, sclk_fall);

endinterface

`default_nettype wire

// File: src/spi_fsm.sv
`default_nettype none

module spi_fsm
    import spi_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  logic    cpol,
    input  logic    cpha,
    spi_ctrl_if.fsm ctrl,
    output logic    busy,
    output logic    done,
    output logic    cs_n
);

    spi_state_t state;
    spi_state_t state_nxt;
    logic       cpol_q;      // Mode frozen for the frame
    logic       cpha_q;
    logic       lead_rise;   // Leading edge is a rise

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            cpol_q <= 1'b0;
            cpha_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == IDLE && start) begin   // Latch mode at start only
                cpol_q <= cpol;
                cpha_q <= cpha;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:     if (start) state_nxt = LOAD;
            LOAD:     state_nxt = TRANSFER;
            TRANSFER: if (ctrl.count_done) state_nxt = FINISH;
            FINISH:   state_nxt = IDLE;
            default:  state_nxt = IDLE;
        endcase
    end

    assign lead_rise = !cpol_q;   // Idle low means first edge rises

    always_comb begin
        ctrl.run            = 1'b0;
        ctrl.load_en        = 1'b0;
        ctrl.shift_en_rise  = 1'b0;
        ctrl.shift_en_fall  = 1'b0;
        ctrl.sample_en_rise = 1'b0;
        ctrl.sample_en_fall = 1'b0;
        case (state)
            LOAD: begin
                ctrl.load_en = 1'b1;
                if (!cpha_q) begin                   // Priming shift, MSB out early
                    ctrl.shift_en_rise = !lead_rise;
                    ctrl.shift_en_fall = lead_rise;
                end
            end
            TRANSFER: begin
                ctrl.run = 1'b1;
                if (!cpha_q) begin                   // Sample leading, shift trailing
                    ctrl.sample_en_rise = lead_rise;
                    ctrl.sample_en_fall = !lead_rise;
                    ctrl.shift_en_rise  = !lead_rise;
                    ctrl.shift_en_fall  = lead_rise;
                end else begin                       // Shift leading, sample trailing
                    ctrl.shift_en_rise  = lead_rise;
                    ctrl.shift_en_fall  = !lead_rise;
                    ctrl.sample_en_rise = !lead_rise;
                    ctrl.sample_en_fall = lead_rise;
                end
            end
            default: ;
        endcase
    end

    assign busy = (state != IDLE);
    assign done = (state == FINISH);                          // Single-cycle pulse
    assign cs_n = !(state == TRANSFER || state == FINISH);    // Rises back in IDLE

endmodule

`default_nettype wire

// File: src/spi_sclk_gen.sv
`default_nettype none

module spi_sclk_gen
    import spi_pkg::*;
#(
    parameter int DATA_W = spi_pkg::DATA_W
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cpol,
    input  clk_div_t div,
    spi_ctrl_if.gen  ctrl,
    output logic     sclk
);

    localparam edge_cnt_t EDGES = edge_cnt_t'(2 * DATA_W);   // Edges per frame

    clk_div_t  half_cnt;   // Cycles into current half period
    edge_cnt_t edge_cnt;   // Edges produced so far
    logic      toggle;     // sclk flips this cycle

    // Terminal count, stops once the frame is complete
    assign toggle = ctrl.run && (half_cnt == div) && (edge_cnt != EDGES);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half_cnt <= '0;
        end else if (!ctrl.run || half_cnt == div) begin   // Reload
            half_cnt <= '0;
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk            <= 1'b0;   // cpol resets to 0
            edge_cnt        <= '0;
            ctrl.sclk_rise  <= 1'b0;
            ctrl.sclk_fall  <= 1'b0;
            ctrl.count_done <= 1'b0;
        end else begin
            ctrl.sclk_rise <= toggle && !sclk;   // Pulse aligned with new level
            ctrl.sclk_fall <= toggle && sclk;
            // One cycle after the final edge pulse
            ctrl.count_done <= ctrl.run && (edge_cnt == EDGES) && !ctrl.count_done;
            if (!ctrl.run) begin
                sclk     <= cpol;   // Rest level
                edge_cnt <= '0;
            end else if (toggle) begin
                sclk     <= !sclk;
                edge_cnt <= edge_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/spi_shift_reg.sv
`default_nettype none

module spi_shift_reg
    import spi_pkg::*;
#(
    parameter int DATA_W = spi_pkg::DATA_W
) (
    input  logic      clk,
    input  logic      rst_n,
    spi_ctrl_if.dp    ctrl,
    input  spi_data_t tx_data,
    input  logic      miso,
    output logic      mosi,
    output spi_data_t rx_data
);

    spi_data_t tx_sr;       // Outgoing bits, MSB next
    spi_data_t rx_sr;       // Incoming bits, fill from LSB
    logic      do_shift;    // Enable met by its edge
    logic      do_sample;
    logic      prime;       // Load with MSB already on mosi

    assign do_shift  = (ctrl.shift_en_rise && ctrl.sclk_rise) ||
                       (ctrl.shift_en_fall && ctrl.sclk_fall);
    assign do_sample = (ctrl.sample_en_rise && ctrl.sclk_rise) ||
                       (ctrl.sample_en_fall && ctrl.sclk_fall);
    assign prime     = ctrl.load_en && (ctrl.shift_en_rise || ctrl.shift_en_fall);

    always_ff @(posedge clk) begin
        if (ctrl.load_en) begin
            tx_sr <= prime ? {tx_data[DATA_W-2:0], 1'b0} : tx_data;
        end else if (do_shift) begin
            tx_sr <= {tx_sr[DATA_W-2:0], 1'b0};
        end
        if (do_sample) rx_sr <= {rx_sr[DATA_W-2:0], miso};   // MSB arrives first
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) mosi <= 1'b0;
        else if (prime) mosi <= tx_data[DATA_W-1];   // cpha 0 setup bit
        else if (do_shift) mosi <= tx_sr[DATA_W-1];
    end

    assign rx_data = rx_sr;

endmodule

`default_nettype wire

// File: src/spi_apb_regs.sv
`default_nettype none

module spi_apb_regs
    import apb_pkg::*;
    import spi_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      cpol,
    output logic      cpha,
    output logic      start,
    output clk_div_t  div,
    output spi_data_t tx_data,
    input  spi_data_t rx_data,
    input  logic      busy,
    input  logic      done
);

    logic wr_acc;      // Write in access phase
    logic start_req;   // Start bit written
    logic busy_any;    // Includes the cycle of the start pulse
    logic done_q;      // Sticky done

    assign pready    = 1'b1;   // No wait states
    assign wr_acc    = psel && penable && pready && pwrite;
    assign start_req = wr_acc && (paddr == REG_CTRL) && pwdata[CTRL_START_BIT];
    assign busy_any  = busy || start;
    assign pslverr   = start_req && busy_any;   // Start while busy is refused

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpol   <= 1'b0;
            cpha   <= 1'b0;
            div    <= '0;
            start  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            start <= start_req && !busy_any;
            if (done) done_q <= 1'b1;
            else if (start_req && !busy_any) done_q <= 1'b0;   // New frame clears it
            if (wr_acc && !pslverr) begin   // Refused write changes nothing
                case (paddr)
                    REG_CTRL: begin
                        cpol <= pwdata[CTRL_CPOL_BIT];
                        cpha <= pwdata[CTRL_CPHA_BIT];
                    end
                    REG_DIV: div <= pwdata[$bits(clk_div_t)-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Picked up by the datapath at the next LOAD
    always_ff @(posedge clk) begin
        if (wr_acc && paddr == REG_TX) tx_data <= pwdata[$bits(spi_data_t)-1:0];
    end

    always_comb begin
        prdata = '0;
        case (paddr)
            REG_CTRL: begin
                prdata[CTRL_CPOL_BIT] = cpol;
                prdata[CTRL_CPHA_BIT] = cpha;
                prdata[STAT_BUSY_BIT] = busy_any;
                prdata[STAT_DONE_BIT] = done_q;
            end
            REG_DIV: prdata = apb_data_t'(div);
            REG_TX:  prdata = apb_data_t'(tx_data);
            REG_RX:  prdata = apb_data_t'(rx_data);
            default: prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/spi_master_top.sv
`default_nettype none

module spi_master_top
    import apb_pkg::*;
    import spi_pkg::*;
#(
    parameter int DATA_W = spi_pkg::DATA_W
) (
    input  logic      clk,
    input  logic      rst_n,
    input  apb_addr_t paddr,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      sclk,
    output logic      mosi,
    input  logic      miso,
    output logic      cs_n
);

    logic      cpol;      // Register mode bits
    logic      cpha;
    logic      start;     // One-cycle start pulse
    logic      busy;
    logic      done;      // Pulse from FINISH
    clk_div_t  div;
    spi_data_t tx_data;
    spi_data_t rx_data;

    spi_ctrl_if ctrl_if ();   // FSM, generator and datapath handshake

    spi_apb_regs regs_i (.clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
                         .prdata, .pready, .pslverr, .cpol, .cpha, .start, .div,
                         .tx_data, .rx_data, .busy, .done);

    spi_fsm fsm_i (.clk, .rst_n, .start, .cpol, .cpha, .ctrl(ctrl_if.fsm),
                   .busy, .done, .cs_n);

    spi_sclk_gen #(.DATA_W(DATA_W)) gen_i (.clk, .rst_n, .cpol, .div,
                                           .ctrl(ctrl_if.gen), .sclk);

    spi_shift_reg #(.DATA_W(DATA_W)) dp_i (.clk, .rst_n, .ctrl(ctrl_if.dp), .tx_data,
                                           .miso, .mosi, .rx_data);

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;
    always #2 clk = ~clk;   // 4 ns period

endmodule

`default_nettype wire

// File: testbench/spi_master_tb.sv
`default_nettype none

module spi_master_tb
    import apb_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic      clk;
    logic      rst_n;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      sclk;
    logic      mosi;
    logic      miso = 1'b0;   // Driven by the slave model
    logic      cs_n;

    logic [7:0] cpol_v[$];   // Test vectors from the data file
    logic [7:0] cpha_v[$];
    logic [7:0] div_v[$];
    logic [7:0] tx_v[$];
    logic [7:0] reply_v[$];

    int mismatches   = 0;
    int other_errors = 0;
    int cycles       = 0;
    int cycle_limit  = 0;    // Zero until the vectors are known

    logic       slv_cpol = 1'b0;   // Slave model mode and reply
    logic       slv_cpha = 1'b0;
    logic [7:0] slv_reply = 8'h00;
    logic [7:0] slv_sr = 8'h00;    // Reply bits still to send
    logic [7:0] captured = 8'h00;  // Bits seen on mosi
    int         edge_seen = 0;     // sclk edges while selected
    logic       cs_prev = 1'b1;
    logic       sclk_prev = 1'b0;
    logic       slv_lead;

    tb_clk_gen clk_gen_i (.clk);

    spi_master_top dut_i (.clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
                          .prdata, .pready, .pslverr, .sclk, .mosi, .miso, .cs_n);

    assign slv_lead = (sclk != slv_cpol);   // Leading edge leaves the idle level

    // SPI slave, edges seen one clk after sclk moves, same as the master's pulses
    always @(posedge clk) begin
        cs_prev   <= cs_n;
        sclk_prev <= sclk;
        if (cs_n) begin
            miso   <= slv_cpha ? 1'b0 : slv_reply[7];   // cpha 0 presents MSB early
            slv_sr <= slv_cpha ? slv_reply : {slv_reply[6:0], 1'b0};
        end else if (cs_prev) begin
            edge_seen <= 0;   // New frame
            captured  <= 8'h00;
        end else if (sclk != sclk_prev) begin
            edge_seen <= edge_seen + 1;
            if (slv_lead != slv_cpha) begin
                captured <= {captured[6:0], mosi};   // Sample edge
            end else begin
                miso   <= slv_sr[7];                 // Shift edge
                slv_sr <= {slv_sr[6:0], 1'b0};
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, transfer never finished", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // One zero-wait APB access, results sampled at the access edge
    task automatic apb_access(input apb_addr_t addr, input logic wr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        compare_value("pready", pready, 1);   // Zero wait states
        rdata = prdata;
        err   = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic run_transfer(input int idx);
        apb_data_t  rd;
        logic       err;
        logic       cp;
        logic       ch;
        logic [7:0] tx;
        logic [7:0] rp;
        cp = cpol_v[idx][0];
        ch = cpha_v[idx][0];
        tx = tx_v[idx];
        rp = reply_v[idx];
        slv_cpol  = cp;
        slv_cpha  = ch;
        slv_reply = rp;
        apb_access(REG_CTRL, 1'b1, {30'b0, ch, cp}, rd, err);
        apb_access(REG_DIV, 1'b1, {24'b0, div_v[idx]}, rd, err);
        apb_access(REG_TX, 1'b1, {24'b0, tx}, rd, err);
        compare_value("cs_n", cs_n, 1);
        compare_value("sclk", sclk, cp);   // Rests at cpol while deselected
        apb_access(REG_CTRL, 1'b1, {29'b0, 1'b1, ch, cp}, rd, err);
        compare_value("pslverr", err, 0);
        apb_access(REG_CTRL, 1'b0, '0, rd, err);
        compare_value("status.done", rd[9], 0);
        compare_value("status.busy", rd[8], 1);
        apb_access(REG_CTRL, 1'b1, {29'b0, 1'b1, ch, cp}, rd, err);   // Refused
        compare_value("pslverr", err, 1);
        apb_access(REG_TX, 1'b1, {24'b0, ~tx}, rd, err);   // Mid-frame rewrite, next start only
        rd = '0;
        while (!rd[9]) apb_access(REG_CTRL, 1'b0, '0, rd, err);
        apb_access(REG_RX, 1'b0, '0, rd, err);
        compare_value("rx_data", rd, {24'b0, rp});
        compare_value("slave_rx", captured, tx);
        compare_value("sclk_edges", edge_seen, 16);
        compare_value("cs_n", cs_n, 1);
        compare_value("sclk", sclk, cp);
    endtask

    initial begin
        int         fd;
        string      line;
        logic [7:0] f0;
        logic [7:0] f1;
        logic [7:0] f2;
        logic [7:0] f3;
        logic [7:0] f4;
        apb_data_t  rd;
        logic       err;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        fd = $fopen("testbench/spi_tests.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the test vector file");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0) break;
                if (line.len() < 2 || line.getc(0) == 8'h23) continue;   // Skip comments
                if ($sscanf(line, "%h %h %h %h %h", f0, f1, f2, f3, f4) == 5) begin
                    cpol_v.push_back(f0);
                    cpha_v.push_back(f1);
                    div_v.push_back(f2);
                    tx_v.push_back(f3);
                    reply_v.push_back(f4);
                end
            end
            $fclose(fd);
        end
        if (tx_v.size() == 0) begin
            other_errors++;
            $display("No test vectors were read");
        end
        cycle_limit = tx_v.size() * (2 * 8 * 4 + 20) + 10 + 20;   // Reset and idle checks
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        compare_value("cs_n", cs_n, 1);
        compare_value("sclk", sclk, 0);
        apb_access(REG_CTRL, 1'b0, '0, rd, err);
        compare_value("status.busy", rd[8], 0);
        compare_value("status.done", rd[9], 0);
        for (int i = 0; i < tx_v.size(); i++) run_transfer(i);
        $display("Checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/spi_tests.txt
# Columns: cpol cpha div tx_byte reply_byte, all hex
# One SPI transfer per line
0 0 0 A5 5A
0 1 0 5A A5
1 0 0 00 FF
1 1 0 FF 00
0 0 1 3C C3
0 1 1 81 7E
1 0 1 12 34
1 1 1 C7 29
0 0 3 FF 00
0 1 3 00 FF
1 0 3 A5 5A
1 1 3 5A A5
0 1 0 6B D2
1 0 1 E4 1F

// File: build.f
src/spi_pkg.sv
src/apb_pkg.sv
src/spi_ctrl_if.sv
src/spi_fsm.sv
src/spi_sclk_gen.sv
src/spi_shift_reg.sv
src/spi_apb_regs.sv
src/spi_master_top.sv
testbench/tb_clk_gen.sv
testbench/spi_master_tb.sv

// File: Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vspi_master_tb: build.f $(wildcard src/*.sv testbench/*.sv)
	verilator --binary --timing --timescale 1ns/1ps -j 0 -f build.f --top-module spi_master_tb

run: obj_dir/Vspi_master_tb
	./obj_dir/Vspi_master_tb | tee sim.log
	grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f build.f --top-module spi_master_top

clean:
	rm -rf obj_dir sim.log
